// ==== logic/mips_pkg.sv ====
/* mips pipeline shared types */
`default_nettype none

package mips_pkg;

    localparam int xlen        = 32;
    localparam int reg_addr_w  = 5;
    localparam int imem_depth  = 256;
    localparam int dmem_depth  = 64;
    localparam int imem_addr_w = 8;
    localparam int dmem_addr_w = 6;
    localparam logic [xlen-1:0] reset_pc = '0;

    typedef enum logic [5:0] {
        op_rtype = 6'h00,
        op_addi  = 6'h08,
        op_lw    = 6'h23,
        op_sw    = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        fn_add = 6'h20,
        fn_sub = 6'h22,
        fn_and = 6'h24,
        fn_or  = 6'h25,
        fn_slt = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {
        alu_add = 3'd0, // zero so an empty ctrl decodes as add
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_slt = 3'd4
    } alu_op_e;

    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    alu_src_imm;
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        ctrl_t                 ctrl;
        logic [xlen-1:0]       rs_val;
        logic [xlen-1:0]       rt_val;
        logic [xlen-1:0]       imm;    // already sign extended
        logic [reg_addr_w-1:0] dest;
    } id_ex_t;

    typedef struct packed {
        ctrl_t                 ctrl;
        logic [xlen-1:0]       alu_result;
        logic [xlen-1:0]       store_data;
        logic [reg_addr_w-1:0] dest;
    } ex_mem_t;

    typedef struct packed {
        logic                  reg_write;
        logic [reg_addr_w-1:0] dest;
        logic [xlen-1:0]       data;
    } wb_t;

    typedef struct packed {
        logic                   we;
        logic [imem_addr_w-1:0] addr;  // word index
        logic [xlen-1:0]        data;
    } prog_wr_t;

endpackage

`default_nettype wire

// ==== logic/register_file.sv ====
/* general register file */
`timescale 1ns/1ps
`default_nettype none

module register_file import mips_pkg::*; (
    input  logic                  SYS_clk,
    input  logic                  SYS_reset,
    input  wb_t                   wr,
    input  logic [reg_addr_w-1:0] ra1,
    input  logic [reg_addr_w-1:0] ra2,
    input  logic [reg_addr_w-1:0] dbg_addr,
    output logic [xlen-1:0]       rd1,
    output logic [xlen-1:0]       rd2,
    output logic [xlen-1:0]       dbg_data
);

    logic [xlen-1:0] regs [32];

    // same-cycle write shows through, r0 stays zero
    function automatic logic [xlen-1:0] read_port(input logic [reg_addr_w-1:0] a);
        if (wr.reg_write && (wr.dest == a) && (a != '0))
            return wr.data;
        return regs[a];
    endfunction

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        else if (wr.reg_write && (wr.dest != '0))
            regs[wr.dest] <= wr.data;
    end

    always_comb
    begin
        rd1      = read_port(ra1);
        rd2      = read_port(ra2);
        dbg_data = read_port(dbg_addr);
    end

endmodule

`default_nettype wire

// ==== logic/fetch_stage.sv ====
/* fetch stage */
`timescale 1ns/1ps
`default_nettype none

module fetch_stage import mips_pkg::*; (
    input  logic            SYS_clk,
    input  logic            SYS_reset,
    input  logic            stall,
    input  prog_wr_t        prog_wr,
    output logic [xlen-1:0] instr
);

    logic [xlen-1:0] pc;
    logic [xlen-1:0] imem [imem_depth];

    // all-zero word is a no-op, so unloaded words are harmless
    initial
    begin
        for (int i = 0; i < imem_depth; i++)
            imem[i] = '0;
    end

    always @(posedge SYS_clk)
    begin
        if (SYS_reset && prog_wr.we) // loading only while core held
            imem[prog_wr.addr] <= prog_wr.data;
    end

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
            pc <= reset_pc;
        else if (!stall)
            pc <= pc + xlen'(4);
    end

    assign instr = imem[pc[imem_addr_w+1:2]]; // word index

endmodule

`default_nettype wire

// ==== logic/decode_stage.sv ====
/* decode stage */
`timescale 1ns/1ps
`default_nettype none

module decode_stage import mips_pkg::*; (
    input  logic                  SYS_clk,
    input  logic                  SYS_reset,
    input  logic                  stall,
    input  logic [xlen-1:0]       instr,
    input  logic                  fwd_rs,
    input  logic                  fwd_rt,
    input  logic [xlen-1:0]       fwd_value,
    input  wb_t                   wb,
    input  logic [reg_addr_w-1:0] dbg_addr,
    output logic [xlen-1:0]       dbg_data,
    output logic [reg_addr_w-1:0] rs,
    output logic [reg_addr_w-1:0] rt,
    output logic                  uses_rt,
    output id_ex_t                id_ex
);

    logic [xlen-1:0]       if_id_instr;
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       rf_rs;
    logic [xlen-1:0]       rf_rt;
    opcode_e               opcode;
    funct_e                funct;
    ctrl_t                 ctrl;
    logic [reg_addr_w-1:0] dest;

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
            if_id_instr <= '0;
        else if (!stall)          // hold while stalled
            if_id_instr <= instr;
    end

    assign opcode = opcode_e'(if_id_instr[31:26]);
    assign funct  = funct_e'(if_id_instr[5:0]);
    assign rs     = if_id_instr[25:21];
    assign rt     = if_id_instr[20:16];
    assign rd     = if_id_instr[15:11];

    assign uses_rt = (opcode == op_rtype) || (opcode == op_sw);

    always_comb
    begin
        ctrl = '0;
        dest = rt;                // addi and lw write rt
        case (opcode)
            op_rtype:
            begin
                dest = rd;
                ctrl.reg_write = 1'b1;
                case (funct)
                    fn_add:  ctrl.alu_op = alu_add;
                    fn_sub:  ctrl.alu_op = alu_sub;
                    fn_and:  ctrl.alu_op = alu_and;
                    fn_or:   ctrl.alu_op = alu_or;
                    fn_slt:  ctrl.alu_op = alu_slt;
                    default: ctrl = '0; // unknown funct, no-op
                endcase
            end
            op_addi:
            begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            op_lw:
            begin
                ctrl.reg_write   = 1'b1;
                ctrl.mem_read    = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            op_sw:
            begin
                ctrl.mem_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            default: ctrl = '0;
        endcase
    end

    register_file regs_i (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .wr        (wb),
        .ra1       (rs),
        .ra2       (rt),
        .dbg_addr  (dbg_addr),
        .rd1       (rf_rs),
        .rd2       (rf_rt),
        .dbg_data  (dbg_data)
    );

    always_comb
    begin
        id_ex.ctrl   = ctrl;
        id_ex.rs_val = fwd_rs ? fwd_value : rf_rs; // forward from mem
        id_ex.rt_val = fwd_rt ? fwd_value : rf_rt;
        id_ex.imm    = {{16{if_id_instr[15]}}, if_id_instr[15:0]};
        id_ex.dest   = dest;
    end

endmodule

`default_nettype wire

// ==== logic/hazard_unit.sv ====
/* stall and forward control */
`timescale 1ns/1ps
`default_nettype none

module hazard_unit import mips_pkg::*; (
    input  logic [reg_addr_w-1:0] rs,
    input  logic [reg_addr_w-1:0] rt,
    input  logic                  uses_rt,
    input  ex_mem_t               ex_view,
    input  ex_mem_t               mem_view,
    output logic                  stall,
    output logic                  fwd_rs,
    output logic                  fwd_rt
);

    logic rs_ex;
    logic rt_ex;
    logic rs_mem;
    logic rt_mem;
    logic mem_is_load;

    function automatic logic src_match(input logic [reg_addr_w-1:0] src,
                                       input ex_mem_t               prod);
        return (src != '0) && prod.ctrl.reg_write && (prod.dest == src);
    endfunction

    assign rs_ex  = src_match(rs, ex_view);
    assign rt_ex  = uses_rt && src_match(rt, ex_view);
    assign rs_mem = src_match(rs, mem_view);
    assign rt_mem = uses_rt && src_match(rt, mem_view);

    assign mem_is_load = mem_view.ctrl.mem_read;

    // anything in execute has no result yet, a load in mem has no data yet
    assign stall = rs_ex || rt_ex || (mem_is_load && (rs_mem || rt_mem));

    // alu result in mem goes straight to decode
    assign fwd_rs = !stall && rs_mem && !mem_is_load;
    assign fwd_rt = !stall && rt_mem && !mem_is_load;

endmodule

`default_nettype wire

// ==== logic/execute_stage.sv ====
/* execute stage and alu */
`timescale 1ns/1ps
`default_nettype none

module execute_stage import mips_pkg::*; (
    input  logic     SYS_clk,
    input  logic     SYS_reset,
    input  logic     stall,
    input  id_ex_t   id_ex,
    output ex_mem_t  ex_out
);

    id_ex_t          id_ex_q;
    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] alu_result;

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
            id_ex_q <= '0;
        else if (stall)
            id_ex_q <= '0;        // bubble behind the stalled decode
        else
            id_ex_q <= id_ex;
    end

    assign op_a = id_ex_q.rs_val;
    assign op_b = id_ex_q.ctrl.alu_src_imm ? id_ex_q.imm : id_ex_q.rt_val;

    always_comb
    begin
        case (id_ex_q.ctrl.alu_op)
            alu_add: alu_result = op_a + op_b;  // wraps
            alu_sub: alu_result = op_a - op_b;
            alu_and: alu_result = op_a & op_b;
            alu_or:  alu_result = op_a | op_b;
            alu_slt: alu_result = ($signed(op_a) < $signed(op_b)) ? xlen'(1) : '0;
            default: alu_result = '0;
        endcase
    end

    always_comb
    begin
        ex_out.ctrl       = id_ex_q.ctrl;
        ex_out.alu_result = alu_result;
        ex_out.store_data = id_ex_q.rt_val;
        ex_out.dest       = id_ex_q.dest;
    end

endmodule

`default_nettype wire

// ==== logic/memory_stage.sv ====
/* memory and writeback */
`timescale 1ns/1ps
`default_nettype none

module memory_stage import mips_pkg::*; (
    input  logic    SYS_clk,
    input  logic    SYS_reset,
    input  ex_mem_t ex_in,
    output ex_mem_t mem_view,
    output wb_t     wb
);

    ex_mem_t         ex_mem_q;
    wb_t             mem_wb_q;
    logic [xlen-1:0] dmem [dmem_depth];
    logic [xlen-1:0] load_data;

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
            ex_mem_q <= '0;
        else
            ex_mem_q <= ex_in;
    end

    // store lands on the same edge the instruction enters mem
    always_ff @(posedge SYS_clk)
    begin
        if (ex_in.ctrl.mem_write)
            dmem[ex_in.alu_result[dmem_addr_w+1:2]] <= ex_in.store_data;
    end

    assign load_data = dmem[ex_mem_q.alu_result[dmem_addr_w+1:2]]; // low bits ignored

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
            mem_wb_q <= '0;
        else
        begin
            mem_wb_q.reg_write <= ex_mem_q.ctrl.reg_write;
            mem_wb_q.dest      <= ex_mem_q.dest;
            mem_wb_q.data      <= ex_mem_q.ctrl.mem_read ? load_data
                                                         : ex_mem_q.alu_result;
        end
    end

    assign mem_view = ex_mem_q;
    assign wb       = mem_wb_q;

endmodule

`default_nettype wire

// ==== logic/mips_core.sv ====
/* five stage mips core */
`timescale 1ns/1ps
`default_nettype none

module mips_core import mips_pkg::*; (
    input  logic                  SYS_clk,
    input  logic                  SYS_reset,
    input  prog_wr_t              prog_wr,
    input  logic [reg_addr_w-1:0] dbg_addr,
    output logic [xlen-1:0]       dbg_data
);

    logic [xlen-1:0]       instr;
    logic                  stall;
    logic                  fwd_rs;
    logic                  fwd_rt;
    logic [reg_addr_w-1:0] rs;
    logic [reg_addr_w-1:0] rt;
    logic                  uses_rt;
    id_ex_t                id_ex;
    ex_mem_t               ex_out;
    ex_mem_t               mem_view;
    wb_t                   wb;

    fetch_stage fetch_i (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .stall     (stall),
        .prog_wr   (prog_wr),
        .instr     (instr)
    );

    decode_stage decode_i (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .stall     (stall),
        .instr     (instr),
        .fwd_rs    (fwd_rs),
        .fwd_rt    (fwd_rt),
        .fwd_value (mem_view.alu_result), // alu result sitting in mem
        .wb        (wb),
        .dbg_addr  (dbg_addr),
        .dbg_data  (dbg_data),
        .rs        (rs),
        .rt        (rt),
        .uses_rt   (uses_rt),
        .id_ex     (id_ex)
    );

    hazard_unit hazard_i (
        .rs       (rs),
        .rt       (rt),
        .uses_rt  (uses_rt),
        .ex_view  (ex_out),
        .mem_view (mem_view),
        .stall    (stall),
        .fwd_rs   (fwd_rs),
        .fwd_rt   (fwd_rt)
    );

    execute_stage execute_i (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .stall     (stall),
        .id_ex     (id_ex),
        .ex_out    (ex_out)
    );

    memory_stage memory_i (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .ex_in     (ex_out),
        .mem_view  (mem_view),
        .wb        (wb)
    );

endmodule

`default_nettype wire

// ==== dv/mips_core_chk.sv ====
/* pipeline control assertions */
`timescale 1ns/1ps
`default_nettype none

module mips_core_chk import mips_pkg::*; (
    input logic            SYS_clk,
    input logic            SYS_reset,
    input logic            stall,
    input logic [xlen-1:0] pc,
    input ex_mem_t         mem_view
);

    // a load-to-use costs at most two bubbles
    stall_bounded: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        (stall && $past(stall)) |=> !stall)
        else $error("stall held for more than two cycles");

    mem_ctrl_exclusive: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        !(mem_view.ctrl.mem_read && mem_view.ctrl.mem_write))
        else $error("load and store both set in memory stage");

    pc_held: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        stall |=> (pc == $past(pc)))
        else $error("pc moved during a stall");

endmodule

bind mips_core mips_core_chk chk_i (
    .SYS_clk   (SYS_clk),
    .SYS_reset (SYS_reset),
    .stall     (stall),
    .pc        (fetch_i.pc),
    .mem_view  (mem_view)
);

`default_nettype wire

// ==== dv/mips_core_tb.sv ====
/* mips core random program testbench */
`timescale 1ns/1ps
`default_nettype none

module mips_core_tb import mips_pkg::*; ();

    localparam int n_clear       = 16;
    localparam int n_random      = 48;
    localparam int n_words       = n_clear + n_random;
    localparam int timeout_limit = 3 * n_random + 20;

    logic                  SYS_clk;
    logic                  SYS_reset;
    prog_wr_t              prog_wr;
    logic [reg_addr_w-1:0] dbg_addr;
    logic [xlen-1:0]       dbg_data;

    logic [31:0]     lfsr;
    int              errors;
    int              checks;
    logic [xlen-1:0] mregs [32];         // reference register file
    logic [xlen-1:0] mmem  [dmem_depth]; // reference data memory

    mips_core dut_i (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .prog_wr   (prog_wr),
        .dbg_addr  (dbg_addr),
        .dbg_data  (dbg_data)
    );

    always #20 SYS_clk = ~SYS_clk;

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] random_instr();
        logic [2:0]  kind;
        logic [4:0]  s;
        logic [4:0]  t;
        logic [4:0]  d;
        logic [5:0]  fn;
        logic [15:0] off;
        kind = 3'(take_bits(3));
        s    = {2'b00, 3'(take_bits(3))}; // r0..r7 for dense dependences
        t    = {2'b00, 3'(take_bits(3))};
        d    = {2'b00, 3'(take_bits(3))};
        // word index bits 7:2 land on a cleared word, low two bits random
        off  = {8'(take_bits(8)), 4'(take_bits(4)), 2'b00, 2'(take_bits(2))};
        case (take_bits(3) % 5)
            0:       fn = 6'h20;
            1:       fn = 6'h22;
            2:       fn = 6'h24;
            3:       fn = 6'h25;
            default: fn = 6'h2a;
        endcase
        case (kind)
            3, 4:    return {6'h08, s, t, 16'(take_bits(16))};
            5:       return {6'h23, 5'd0, t, off};
            6:       return {6'h2b, 5'd0, t, off};
            default: return {6'h00, s, t, d, 5'd0, fn};
        endcase
    endfunction

    // sequential instruction-set model
    task automatic model_step(input logic [31:0] w);
        logic [4:0]  d;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] addr;
        logic [31:0] r;
        logic        wr;
        a    = mregs[w[25:21]];
        b    = mregs[w[20:16]];
        imm  = {{16{w[15]}}, w[15:0]};
        addr = a + imm;
        d    = w[20:16];
        r    = '0;
        wr   = 1'b1;
        case (w[31:26])
            6'h00:
            begin
                d = w[15:11];
                case (w[5:0])
                    6'h20:   r = a + b;
                    6'h22:   r = a - b;
                    6'h24:   r = a & b;
                    6'h25:   r = a | b;
                    6'h2a:   r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: wr = 1'b0;
                endcase
            end
            6'h08:   r = addr;
            6'h23:   r = mmem[addr[7:2]];
            6'h2b:
            begin
                mmem[addr[7:2]] = b;
                wr = 1'b0;
            end
            default: wr = 1'b0;
        endcase
        if (wr && (d != 5'd0))
            mregs[d] = r;
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("FAILED %s got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic end_run();
        $display("mips_core_tb done, %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    endtask

    task automatic check_regs();
        for (int i = 0; i < 32; i++)
        begin
            @(negedge SYS_clk);
            dbg_addr = reg_addr_w'(i);
            #1;
            compare_value($sformatf("dbg_data[r%0d]", i), dbg_data, mregs[i]);
        end
    endtask

    task automatic wait_pc(input logic [xlen-1:0] target);
        int cycles;
        cycles = 0;
        while ((dut_i.fetch_i.pc < target) && (cycles < timeout_limit))
        begin
            @(negedge SYS_clk);
            cycles++;
        end
        if (dut_i.fetch_i.pc < target)
        begin
            errors++;
            $display("timeout, pc stuck at 0x%08h while waiting for 0x%08h",
                     dut_i.fetch_i.pc, target);
            end_run();
        end
    endtask

    task automatic run_program();
        logic [31:0] prog [n_words];
        for (int k = 0; k < n_clear; k++)
            prog[k] = {6'h2b, 5'd0, 5'd0, 16'(k * 16)}; // sw r0 clears dmem
        for (int k = n_clear; k < n_words; k++)
            prog[k] = random_instr();
        for (int i = 0; i < 32; i++)
            mregs[i] = '0;
        for (int i = 0; i < dmem_depth; i++)
            mmem[i] = '0;
        @(negedge SYS_clk);
        SYS_reset = 1'b1;
        repeat (8) @(negedge SYS_clk);
        check_regs();               // all zero while held in reset
        for (int k = 0; k < n_words; k++)
        begin
            @(negedge SYS_clk);
            prog_wr = '{we: 1'b1, addr: imem_addr_w'(k), data: prog[k]};
        end
        for (int k = 0; k < n_words; k++)
            model_step(prog[k]);
        @(negedge SYS_clk);
        prog_wr   = '0;
        SYS_reset = 1'b0;
        wait_pc(xlen'(4 * n_clear));
        wait_pc(xlen'(4 * (n_words + 5))); // last writeback drained
        check_regs();
    endtask

    initial
    begin
        SYS_clk   = 1'b0;
        SYS_reset = 1'b1;
        prog_wr   = '0;
        dbg_addr  = '0;
        errors    = 0;
        checks    = 0;
        lfsr      = 32'h3262d3be;
        run_program();
        run_program();              // fresh reset, new program
        end_run();
    end

endmodule

`default_nettype wire

// ==== mips_core.f ====
logic/mips_pkg.sv
logic/register_file.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/hazard_unit.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/mips_core.sv
dv/mips_core_chk.sv
dv/mips_core_tb.sv

// ==== Bender.yml ====
package:
  name: mips_core

sources:
  - logic/mips_pkg.sv
  - logic/register_file.sv
  - logic/fetch_stage.sv
  - logic/decode_stage.sv
  - logic/hazard_unit.sv
  - logic/execute_stage.sv
  - logic/memory_stage.sv
  - logic/mips_core.sv
  - target: simulation
    files:
      - dv/mips_core_chk.sv
      - dv/mips_core_tb.sv
